//--- common/istream_consts.svh
// Buffer sizing constants; the block queue needs a power-of-two set count of at least 2

`ifndef ISTREAM_CONSTS_SVH
`define ISTREAM_CONSTS_SVH

// ----------------------------------------------------------------------------
// Fetch block geometry

// 2-byte parcels in one 16-byte fetch block
`define ISTREAM_PARCELS 8

// ----------------------------------------------------------------------------
// Dequeue side

// Most instructions handed to decode per cycle
`define ISTREAM_WAYS 4

// ----------------------------------------------------------------------------
// Storage and reset state

// Default block capacity of the queue
`define ISTREAM_SETS_DEFAULT 8

// Dequeue PC out of reset
`define ISTREAM_INIT_PC 32'h0000_0000

`endif

//--- common/istream_pkg.sv
// Instruction stream buffer types; block and way layouts follow the widths in istream_consts.svh

`default_nettype none

`include "istream_consts.svh"

package istream_pkg;

	// ------------------------------------------------------------------------
	// Fetch side

	// One 16-bit instruction parcel
	typedef logic [15:0] parcel_t;

	// 16-byte block as pushed by fetch, parcel 0 at the lowest address
	typedef struct packed {
		logic [`ISTREAM_PARCELS-1:0]    valid;
		logic [`ISTREAM_PARCELS-1:0]    redirect;
		parcel_t [`ISTREAM_PARCELS-1:0] parcels;
		logic [31:0]                    start_pc;
		logic                           page_fault;
		logic                           access_fault;
	} fetch_block_t;

	// ------------------------------------------------------------------------
	// Decode side

	// Parcel view, lo is the parcel at the lower address
	typedef struct packed {
		parcel_t hi;
		parcel_t lo;
	} istream_halves_t;

	// Built parcel by parcel by the aligner, read whole by decode
	typedef union packed {
		logic [31:0]     word;
		istream_halves_t half;
	} istream_instr_u;

	typedef struct packed {
		logic           valid;
		logic           uncompressed;
		istream_instr_u instr;
		logic [31:0]    pc;
		logic           page_fault;
		logic           access_fault;
		// Taken from the last parcel of the instruction
		logic           redirect;
	} istream_way_t;

	// Way 0 is the oldest instruction
	typedef struct packed {
		logic                             valid;
		istream_way_t [`ISTREAM_WAYS-1:0] ways;
	} istream_deq_t;

endpackage

`default_nettype wire

//--- istream/istream_block_queue.sv
// Circular fetch block store; ISTREAM_SETS must be a power of two of 2 or more, stall only when full

`default_nettype none

`include "istream_consts.svh"

module istream_block_queue #(
	parameter int ISTREAM_SETS = `ISTREAM_SETS_DEFAULT
) (
	input  logic                      CLK,
	input  logic                      nRST,

	// Fetch side
	input  logic                      enq_valid,
	input  istream_pkg::fetch_block_t enq_block,
	output logic                      enq_stall,

	// Aligner side
	input  logic                      pop_head,
	output istream_pkg::fetch_block_t head_block,
	output logic                      head_present,
	output istream_pkg::fetch_block_t next_block,
	output logic                      next_present,

	input  logic                      restart
);

	import istream_pkg::*;

	localparam int PTR_W = $clog2(ISTREAM_SETS);
	localparam int CNT_W = PTR_W + 1;

	// ------------------------------------------------------------------------
	// Storage and pointers

	fetch_block_t     blocks [ISTREAM_SETS];

	logic [PTR_W-1:0] head_ptr;
	logic [PTR_W-1:0] tail_ptr;
	logic [PTR_W-1:0] next_ptr;
	logic [CNT_W-1:0] count;

	logic             do_enq;
	logic             do_pop;

	// ------------------------------------------------------------------------
	// Handshake

	// Stall depends on occupancy only, a same-cycle pop does not free a slot
	assign enq_stall = (count == CNT_W'(ISTREAM_SETS));

	// A block arriving with restart is dropped
	assign do_enq = enq_valid && !enq_stall && !restart;
	assign do_pop = pop_head && head_present && !restart;

	// ------------------------------------------------------------------------
	// Read ports

	// Pointer width wraps naturally for a power-of-two depth
	assign next_ptr = head_ptr + 1'b1;

	assign head_present = (count != '0);
	assign next_present = (count > CNT_W'(1));

	assign head_block = blocks[head_ptr];
	assign next_block = blocks[next_ptr];

	// ------------------------------------------------------------------------
	// Block payload

	always_ff @(posedge CLK) begin
		if (do_enq) begin
			blocks[tail_ptr] <= enq_block;
		end
	end

	// ------------------------------------------------------------------------
	// Occupancy

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else if (restart) begin
			// Flush everything, including the block offered this cycle
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else begin
			if (do_enq) begin
				tail_ptr <= tail_ptr + 1'b1;
			end
			if (do_pop) begin
				head_ptr <= head_ptr + 1'b1;
			end

			// Enqueue and pop together leave the count unchanged
			case ({do_enq, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- istream/istream_parcel_align.sv
// Parcel aligner; a block whose remaining parcels are all invalid costs one empty dequeue cycle

`default_nettype none

`include "istream_consts.svh"

module istream_parcel_align (
	input  logic                      CLK,
	input  logic                      nRST,

	// Queue side
	input  istream_pkg::fetch_block_t head_block,
	input  logic                      head_present,
	input  istream_pkg::fetch_block_t next_block,
	input  logic                      next_present,
	output logic                      pop_head,

	// Decode side
	output istream_pkg::istream_deq_t deq,
	input  logic                      deq_stall,

	input  logic                      restart
);

	import istream_pkg::*;

	localparam int P      = `ISTREAM_PARCELS;
	localparam int W      = `ISTREAM_WAYS;
	localparam int OFS_W  = $clog2(P) + 1;
	localparam int SLOT_W = $clog2(2 * P);

	// ------------------------------------------------------------------------
	// State and walk results

	// Offset runs 0..P, P means the head block is used up
	logic [OFS_W-1:0]  offset;
	logic [OFS_W-1:0]  offset_d;
	logic [31:0]       deq_pc;

	logic [P-1:0]      head_live;
	logic [P-1:0]      next_live;
	logic [2*P-1:0]    slot_ok;
	logic              head_exhausted;

	logic [SLOT_W-1:0] last_slot;
	logic [31:0]       end_pc;
	logic              accept;
	logic              head_rest;

	// Parcels after the first valid redirect belong to the wrong path
	function automatic logic [P-1:0] live_mask(input fetch_block_t blk);
		logic [P-1:0] mask;
		logic         cut;
		mask = '0;
		cut  = 1'b0;
		for (int i = 0; i < P; i++) begin
			mask[i] = blk.valid[i] && !cut;
			if (blk.valid[i] && blk.redirect[i]) begin
				cut = 1'b1;
			end
		end
		return mask;
	endfunction

	assign head_live = live_mask(head_block);
	assign next_live = live_mask(next_block);

	// ------------------------------------------------------------------------
	// Slot map, slots 0..P-1 are the head block and P..2P-1 the next block

	always_comb begin
		for (int i = 0; i < P; i++) begin
			slot_ok[i] = head_present && head_live[i] && (OFS_W'(i) >= offset);
		end

		head_exhausted = head_present && !(|slot_ok[P-1:0]);

		// Nothing is shown while a used-up head is dropped
		for (int i = 0; i < P; i++) begin
			slot_ok[P+i] = next_present && next_live[i] && !head_exhausted;
		end
	end

	// ------------------------------------------------------------------------
	// Way formation

	always_comb begin : walk
		fetch_block_t blk;
		istream_way_t cur;
		int           w;
		int           idx;
		int           last;
		logic         pending;

		w       = 0;
		last    = 0;
		pending = 1'b0;
		cur     = '0;
		end_pc  = deq_pc;

		// Idle ways carry the dequeue PC
		for (int i = 0; i < W; i++) begin
			deq.ways[i]    = '0;
			deq.ways[i].pc = deq_pc;
		end

		for (int s = 0; s < 2 * P; s++) begin
			blk = (s < P) ? head_block : next_block;
			idx = s % P;
			if (slot_ok[s] && (w < W)) begin
				if (pending) begin
					// Upper half of a 32-bit instruction, possibly from the next block
					cur.instr.half.hi = blk.parcels[idx];
					cur.redirect      = blk.redirect[idx];
					cur.page_fault    = cur.page_fault | blk.page_fault;
					cur.access_fault  = cur.access_fault | blk.access_fault;
					cur.valid         = 1'b1;
					pending           = 1'b0;
				end else begin
					cur                = '0;
					cur.pc             = blk.start_pc + 32'(2 * idx);
					cur.instr.half.lo  = blk.parcels[idx];
					cur.redirect       = blk.redirect[idx];
					cur.page_fault     = blk.page_fault;
					cur.access_fault   = blk.access_fault;
					// Faulting parcels go out one by one as compressed
					if (!blk.page_fault && !blk.access_fault &&
					    (blk.parcels[idx][1:0] == 2'b11)) begin
						cur.uncompressed = 1'b1;
						pending          = 1'b1;
					end else begin
						cur.valid = 1'b1;
					end
				end

				if (cur.valid) begin
					deq.ways[w] = cur;
					last        = s;
					end_pc      = cur.pc + (cur.uncompressed ? 32'd4 : 32'd2);
					w           = w + 1;
				end
			end
		end

		// A dangling upper half leaves its instruction hidden
		deq.valid = (w != 0);
		last_slot = SLOT_W'(last);
	end

	// ------------------------------------------------------------------------
	// Offset advance and head pop

	always_comb begin
		accept    = deq.valid && !deq_stall;
		head_rest = 1'b0;
		for (int i = 0; i < P; i++) begin
			if (slot_ok[i] && (SLOT_W'(i) > last_slot)) begin
				head_rest = 1'b1;
			end
		end

		pop_head = head_exhausted ||
		           (accept && ((last_slot >= SLOT_W'(P)) || !head_rest));

		if (head_exhausted) begin
			offset_d = '0;
		end else if (accept) begin
			if (last_slot >= SLOT_W'(P)) begin
				// Walk ended inside the next block, carry the remainder
				offset_d = OFS_W'(last_slot - SLOT_W'(P)) + 1'b1;
			end else if (head_rest) begin
				offset_d = OFS_W'(last_slot) + 1'b1;
			end else begin
				offset_d = '0;
			end
		end else begin
			offset_d = offset;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			offset <= '0;
			deq_pc <= `ISTREAM_INIT_PC;
		end else if (restart) begin
			offset <= '0;
		end else begin
			offset <= offset_d;
			if (accept) begin
				deq_pc <= end_pc;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/istream_top.sv
// Instruction stream buffer top; restart_pc is accepted but unused, block start PCs come from fetch

`default_nettype none

module istream_top (
	input  logic                      CLK,
	input  logic                      nRST,

	// Fetch side
	input  logic                      enq_valid,
	input  istream_pkg::fetch_block_t enq_block,
	output logic                      enq_stall,

	// Decode side
	output istream_pkg::istream_deq_t deq,
	input  logic                      deq_stall,

	// Frontend restart
	input  logic                      restart,
	input  logic [31:0]               restart_pc
);

	import istream_pkg::*;

	// ------------------------------------------------------------------------
	// Queue to aligner

	fetch_block_t head_block;
	fetch_block_t next_block;
	logic         head_present;
	logic         next_present;
	logic         pop_head;

	istream_block_queue istream_block_queue_inst (
		.CLK          (CLK),
		.nRST         (nRST),
		.enq_valid    (enq_valid),
		.enq_block    (enq_block),
		.enq_stall    (enq_stall),
		.pop_head     (pop_head),
		.head_block   (head_block),
		.head_present (head_present),
		.next_block   (next_block),
		.next_present (next_present),
		.restart      (restart)
	);

	istream_parcel_align istream_parcel_align_inst (
		.CLK          (CLK),
		.nRST         (nRST),
		.head_block   (head_block),
		.head_present (head_present),
		.next_block   (next_block),
		.next_present (next_present),
		.pop_head     (pop_head),
		.deq          (deq),
		.deq_stall    (deq_stall),
		.restart      (restart)
	);

endmodule

`default_nettype wire

//--- src.f
+incdir+common
common/istream_pkg.sv
istream/istream_block_queue.sv
istream/istream_parcel_align.sv
rtl/istream_top.sv
verification/tb_clock_gen.sv
verification/tb_istream.sv

//--- verification/tb_clock_gen.sv
// Free-running testbench clock; reset is released once on a rising edge and never asserted again

`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic CLK,
	output logic nRST
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		CLK = 1'b0;
		forever begin
			#(PERIOD_NS / 2) CLK = ~CLK;
		end
	end

	// Low through the first reset cycles
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
	end

endmodule

`default_nettype wire

//--- verification/tb_istream.sv
// Testbench for istream_top; assumes the default set count, no all-invalid blocks, compressed blocks under hold

`default_nettype none

`include "istream_consts.svh"

module tb_istream;

	timeunit 1ns;
	timeprecision 1ps;

	import istream_pkg::*;

	localparam int PARCELS = `ISTREAM_PARCELS;
	localparam int WAYS    = `ISTREAM_WAYS;
	localparam int SETS    = `ISTREAM_SETS_DEFAULT;

	// One table row, applied for a single cycle
	typedef struct packed {
		logic [3:0]   test_id;
		logic         enq;
		logic         rst;
		logic         hold;
		fetch_block_t blk;
	} stim_t;

	logic         CLK;
	logic         nRST;
	logic         enq_valid;
	fetch_block_t enq_block;
	logic         enq_stall;
	istream_deq_t deq;
	logic         deq_stall;
	logic         restart;
	logic [31:0]  restart_pc;

	// Reference model and bookkeeping
	stim_t        stim [$];
	istream_way_t exp_q [$];
	istream_way_t pend_way;
	logic         pend_valid;
	logic         after_restart;
	logic         running;
	logic         cur_hold;
	logic [15:0]  lfsr_state;
	int           fill_count;
	int           err_count;
	int           check_count;
	int           cycle_count;
	int           cycle_limit;
	string        test_names [1:6];

	tb_clock_gen tb_clock_gen_inst (
		.CLK  (CLK),
		.nRST (nRST)
	);

	istream_top istream_top_inst (
		.CLK        (CLK),
		.nRST       (nRST),
		.enq_valid  (enq_valid),
		.enq_block  (enq_block),
		.enq_stall  (enq_stall),
		.deq        (deq),
		.deq_stall  (deq_stall),
		.restart    (restart),
		.restart_pc (restart_pc)
	);

	// --------------------------------------------------------------------------
	// Pseudo-random stall source

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bit(output logic b);
		lfsr_state = lfsr_next(lfsr_state);
		b = lfsr_state[0];
	endtask

	// --------------------------------------------------------------------------
	// Compare tasks

	function automatic string way_text(input istream_way_t w);
		return $sformatf("v=%b pc=%h instr=%h unc=%b pf=%b af=%b rd=%b", w.valid, w.pc,
			w.instr.word, w.uncompressed, w.page_fault, w.access_fault, w.redirect);
	endfunction

	task automatic check_way(input string name, input istream_way_t exp, input istream_way_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("[FAIL] %0t ns %s: expected %s, got %s", $time, name,
				way_text(exp), way_text(act));
		end
	endtask

	task automatic check_stall(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("[FAIL] %0t ns %s: expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic report_error(input string what);
		err_count++;
		$display("%s at %0t ns", what, $time);
	endtask

	// --------------------------------------------------------------------------
	// Reference model, one expected entry per instruction in program order

	task automatic model_add_block(input fetch_block_t blk);
		istream_way_t w;
		logic         cut;
		cut = 1'b0;
		for (int i = 0; i < PARCELS; i++) begin
			if (blk.valid[i] && !cut) begin
				if (pend_valid) begin
					// Second half may come from a later block
					w                 = pend_way;
					w.instr.half.hi   = blk.parcels[i];
					w.redirect        = blk.redirect[i];
					w.page_fault      = w.page_fault | blk.page_fault;
					w.access_fault    = w.access_fault | blk.access_fault;
					pend_valid        = 1'b0;
					exp_q.push_back(w);
				end else begin
					w                 = '0;
					w.valid           = 1'b1;
					w.pc              = blk.start_pc + 32'(2 * i);
					w.instr.half.lo   = blk.parcels[i];
					w.redirect        = blk.redirect[i];
					w.page_fault      = blk.page_fault;
					w.access_fault    = blk.access_fault;
					if (!blk.page_fault && !blk.access_fault && blk.parcels[i][1:0] == 2'b11) begin
						w.uncompressed = 1'b1;
						pend_way       = w;
						pend_valid     = 1'b1;
					end else begin
						exp_q.push_back(w);
					end
				end
				// Rest of the block is wrong-path
				if (blk.redirect[i]) begin
					cut = 1'b1;
				end
			end
		end
	endtask

	task automatic check_deq();
		int   shown;
		logic gap;
		shown = 0;
		gap   = 1'b0;
		for (int i = 0; i < WAYS; i++) begin
			if (deq.ways[i].valid) begin
				if (gap) begin
					report_error($sformatf("Way %0d is valid after an empty way", i));
				end else if (shown >= exp_q.size()) begin
					report_error($sformatf("Unexpected instruction on deq.ways[%0d], pc %h",
						i, deq.ways[i].pc));
				end else begin
					check_way($sformatf("deq.ways[%0d]", i), exp_q[shown], deq.ways[i]);
				end
				shown++;
			end else begin
				gap = 1'b1;
			end
		end
		// Stalled compressed blocks show their oldest ways and keep them
		if (cur_hold) begin
			check_stall("deq.valid", exp_q.size() != 0, deq.valid);
			for (int i = 0; i < WAYS; i++) begin
				check_stall($sformatf("deq.ways[%0d].valid", i), i < exp_q.size(),
					deq.ways[i].valid);
			end
		end
		// Consumed at the coming edge
		if (deq.valid && !deq_stall) begin
			for (int i = 0; i < shown && exp_q.size() != 0; i++) begin
				void'(exp_q.pop_front());
			end
		end
	endtask

	always @(negedge CLK) begin : monitor
		logic full;
		if (nRST && running) begin
			if (restart) begin
				exp_q.delete();
				pend_valid    = 1'b0;
				fill_count    = 0;
				after_restart = 1'b1;
			end else begin
				if (after_restart) begin
					check_stall("deq.valid after restart", 1'b0, deq.valid);
					after_restart = 1'b0;
				end
				check_deq();
				if (enq_valid) begin
					// Only the stalled fill can reach a full queue
					full = cur_hold && (fill_count == SETS);
					check_stall("enq_stall", full, enq_stall);
					if (!full) begin
						fill_count++;
						model_add_block(enq_block);
					end
				end
			end
		end
	end

	// --------------------------------------------------------------------------
	// Stimulus table

	function automatic fetch_block_t comp_block(input logic [31:0] pc);
		fetch_block_t b;
		b          = '0;
		b.valid    = '1;
		b.start_pc = pc;
		for (int i = 0; i < PARCELS; i++) begin
			b.parcels[i] = {pc[13:4], 3'(i), 3'b001};
		end
		return b;
	endfunction

	task automatic add_entry(input int id, input logic enq, input logic rst, input logic hold,
		input fetch_block_t blk);
		stim_t e;
		e.test_id = 4'(id);
		e.enq     = enq;
		e.rst     = rst;
		e.hold    = hold;
		e.blk     = blk;
		stim.push_back(e);
	endtask

	task automatic build_table();
		fetch_block_t b;
		// In-order compressed stream
		for (int k = 0; k < 3; k++) begin
			add_entry(1, 1'b1, 1'b0, 1'b0, comp_block(32'h1000 + 32'(16 * k)));
		end
		// 32-bit instructions, the last one spans into the next block
		b = comp_block(32'h2000);
		b.parcels[1] = 16'h4a13;
		b.parcels[2] = 16'h00b5;
		b.parcels[4] = 16'h7f03;
		b.parcels[5] = 16'h1234;
		b.parcels[7] = 16'hc0f7;
		add_entry(2, 1'b1, 1'b0, 1'b0, b);
		repeat (3) add_entry(2, 1'b0, 1'b0, 1'b0, '0);
		b = comp_block(32'h2010);
		b.parcels[0] = 16'h5a5a;
		add_entry(2, 1'b1, 1'b0, 1'b0, b);
		// Holes and a redirect, the redirect on an invalid parcel does nothing
		b = comp_block(32'h3000);
		b.valid    = 8'b1011_0110;
		b.redirect = 8'b0001_0001;
		add_entry(3, 1'b1, 1'b0, 1'b0, b);
		b = comp_block(32'h3010);
		b.valid = 8'b1111_1100;
		add_entry(3, 1'b1, 1'b0, 1'b0, b);
		b = comp_block(32'h3020);
		b.valid      = 8'b1101_1011;
		b.redirect   = 8'b1000_0000;
		b.parcels[1] = 16'h9ab3;
		add_entry(3, 1'b1, 1'b0, 1'b0, b);
		// Fill with decode stalled, the last two blocks meet enq_stall
		add_entry(4, 1'b0, 1'b1, 1'b1, '0);
		for (int k = 0; k < SETS + 2; k++) begin
			add_entry(4, 1'b1, 1'b0, 1'b1, comp_block(32'h4000 + 32'(16 * k)));
		end
		// Faulting blocks
		add_entry(5, 1'b1, 1'b0, 1'b0, comp_block(32'h5000));
		b = comp_block(32'h5010);
		b.page_fault = 1'b1;
		b.parcels[2] = 16'h1233;
		b.parcels[5] = 16'hffff;
		add_entry(5, 1'b1, 1'b0, 1'b0, b);
		b = comp_block(32'h5020);
		b.access_fault = 1'b1;
		b.parcels[0]   = 16'h0103;
		add_entry(5, 1'b1, 1'b0, 1'b0, b);
		add_entry(5, 1'b1, 1'b0, 1'b0, comp_block(32'h5030));
		// Restart with blocks in flight, the block offered with it is dropped
		add_entry(6, 1'b0, 1'b1, 1'b1, '0);
		for (int k = 0; k < 3; k++) begin
			add_entry(6, 1'b1, 1'b0, 1'b1, comp_block(32'h6000 + 32'(16 * k)));
		end
		add_entry(6, 1'b1, 1'b1, 1'b1, comp_block(32'h6ff0));
		add_entry(6, 1'b1, 1'b0, 1'b0, comp_block(32'h7000));
		add_entry(6, 1'b1, 1'b0, 1'b0, comp_block(32'h7010));
	endtask

	task automatic apply_entry(input stim_t e);
		logic b0;
		logic b1;
		take_bit(b0);
		take_bit(b1);
		@(posedge CLK);
		enq_valid <= e.enq;
		enq_block <= e.blk;
		restart   <= e.rst;
		deq_stall <= e.hold | (b0 & b1);
		cur_hold  <= e.hold;
	endtask

	// Idle cycles until every expected instruction has been taken
	task automatic drain();
		stim_t idle;
		idle = '0;
		apply_entry(idle);
		while (exp_q.size() != 0) begin
			apply_entry(idle);
		end
	endtask

	// --------------------------------------------------------------------------
	// Run limit

	always @(posedge CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Run stopped after %0d cycles without finishing", cycle_count);
			if (exp_q.size() != 0) begin
				$display("%0d expected instructions never appeared on deq", exp_q.size());
			end
			$display("Simulation failed");
			$finish;
		end
	end

	// --------------------------------------------------------------------------
	// Main sequence

	initial begin
		int           first_err;
		istream_way_t idle_way;
		enq_valid     = 1'b0;
		enq_block     = '0;
		deq_stall     = 1'b0;
		restart       = 1'b0;
		restart_pc    = 32'h0;
		pend_way      = '0;
		pend_valid    = 1'b0;
		after_restart = 1'b0;
		running       = 1'b0;
		cur_hold      = 1'b0;
		lfsr_state    = 16'd9615;
		fill_count    = 0;
		err_count     = 0;
		check_count   = 0;
		cycle_count   = 0;
		test_names    = '{"compressed stream in order", "32-bit and spanning instructions",
			"holes and redirect", "full queue under stall", "page and access faults",
			"restart mid-stream"};
		build_table();
		cycle_limit = 4 * stim.size() + 200;

		// Idle ways out of reset carry the initial dequeue PC
		idle_way    = '0;
		idle_way.pc = `ISTREAM_INIT_PC;

		wait (nRST === 1'b1);
		@(negedge CLK);
		check_stall("enq_stall", 1'b0, enq_stall);
		check_stall("deq.valid", 1'b0, deq.valid);
		for (int i = 0; i < WAYS; i++) begin
			check_way($sformatf("deq.ways[%0d]", i), idle_way, deq.ways[i]);
		end
		@(posedge CLK);
		running = 1'b1;

		first_err = err_count;
		for (int k = 0; k < stim.size(); k++) begin
			apply_entry(stim[k]);
			if (k == stim.size() - 1 || stim[k + 1].test_id != stim[k].test_id) begin
				drain();
				if (err_count == first_err) begin
					$display("Test %0d %s: ok", stim[k].test_id, test_names[stim[k].test_id]);
				end else begin
					$display("Test %0d %s: %0d errors", stim[k].test_id,
						test_names[stim[k].test_id], err_count - first_err);
				end
				first_err = err_count;
			end
		end

		$display("6 tests, %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
